// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and register index widths
`define WORD_W      32
`define REG_ADDR_W  4

// r15 reads as the pc
`define PC_REG      4'd15

// fetch stepping
`define PC_STEP     32'd4
`define PC_RESET    32'h0000_0000

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // instruction class, bits 27:26
    typedef enum logic [1:0] {
        DATA   = 2'b00,
        MEMORY = 2'b01,
        BRANCH = 2'b10
    } op_class_e;

    // data-processing opcode, bits 24:21
    typedef enum logic [3:0] {
        AND = 4'b0000,
        SUB = 4'b0010,
        ADD = 4'b0100,
        CMP = 4'b1010,
        ORR = 4'b1100,
        MOV = 4'b1101
    } alu_cmd_e;

    // condition field, bits 31:28
    typedef enum logic [3:0] {
        EQ = 4'b0000,
        NE = 4'b0001,
        MI = 4'b0100,
        PL = 4'b0101,
        AL = 4'b1110
    } cond_e;

    typedef enum logic [1:0] {IMM8, IMM12, BR24} imm_src_e;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    // operand source seen by the execute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    input  logic [`WORD_W-1:0]     pc_plus8,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`WORD_W-1:0]     wd,
    output logic [`WORD_W-1:0]     rd1,
    output logic [`WORD_W-1:0]     rd2
);

    // r0 to r14 only
    logic [`WORD_W-1:0] regs [0:14];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != `PC_REG) begin
            regs[wa] <= wd;
        end
    end

    // r15 first, then same-cycle writeback bypass
    function automatic logic [`WORD_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] ra);
        if (ra == `PC_REG) begin
            return pc_plus8;
        end else if (we && wa == ra) begin
            return wd;
        end else begin
            return regs[ra];
        end
    endfunction

    assign rd1 = read_port(ra1);
    assign rd2 = read_port(ra2);

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`WORD_W-1:0]     instr_f,
    input  logic [`WORD_W-1:0]     pc_f,
    input  logic                   stall_f_d,
    input  logic                   flush_d,
    input  logic                   reg_write_w,
    input  logic [`REG_ADDR_W-1:0] wa3_w,
    input  logic [`WORD_W-1:0]     result_w,
    output logic [`REG_ADDR_W-1:0] ra1_d,
    output logic [`REG_ADDR_W-1:0] ra2_d,
    output logic [`REG_ADDR_W-1:0] wa3_d,
    output logic [`WORD_W-1:0]     rd1_d,
    output logic [`WORD_W-1:0]     rd2_d,
    output logic [`WORD_W-1:0]     ext_imm_d,
    output isa_pkg::alu_cmd_e      alu_cmd_d,
    output isa_pkg::cond_e         cond_d,
    output logic                   alu_src_d,
    output logic                   set_flags_d,
    output logic                   reg_write_d,
    output logic                   mem_write_d,
    output logic                   mem_to_reg_d,
    output logic                   branch_d
);
    import isa_pkg::*;

    logic [`WORD_W-1:0] instr_d;
    logic [`WORD_W-1:0] pc_d;
    logic               valid_d;
    op_class_e          op_class;
    imm_src_e           imm_src;
    logic               is_cmp;

    ////////////////////
    // if/id register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d <= 1'b0;
        end else if (flush_d) begin
            valid_d <= 1'b0;
        end else if (!stall_f_d) begin
            valid_d <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_f_d) begin
            instr_d <= instr_f;
            pc_d    <= pc_f;
        end
    end

    ////////////////////
    // control decode
    assign op_class = op_class_e'(instr_d[27:26]);
    assign cond_d   = cond_e'(instr_d[31:28]);
    assign wa3_d    = instr_d[15:12];
    assign is_cmp   = alu_cmd_e'(instr_d[24:21]) == CMP;

    // str reads rd as store data
    assign ra2_d = mem_write_d ? instr_d[15:12] : instr_d[3:0];

    always_comb begin
        alu_cmd_d    = ADD;
        alu_src_d    = 1'b1;
        imm_src      = IMM8;
        set_flags_d  = 1'b0;
        reg_write_d  = 1'b0;
        mem_write_d  = 1'b0;
        mem_to_reg_d = 1'b0;
        branch_d     = 1'b0;
        ra1_d        = instr_d[19:16];
        if (valid_d) begin
            case (op_class)
                DATA: begin
                    alu_cmd_d   = alu_cmd_e'(instr_d[24:21]);
                    alu_src_d   = instr_d[25];
                    set_flags_d = instr_d[20] || is_cmp;
                    reg_write_d = !is_cmp;
                end
                MEMORY: begin
                    // bit 20 is L here
                    imm_src      = IMM12;
                    reg_write_d  = instr_d[20];
                    mem_to_reg_d = instr_d[20];
                    mem_write_d  = !instr_d[20];
                end
                BRANCH: begin
                    imm_src  = BR24;
                    branch_d = 1'b1;
                    ra1_d    = `PC_REG;
                end
                default: begin
                    branch_d = 1'b0;
                end
            endcase
        end
        // r15 is never written
        if (wa3_d == `PC_REG) begin
            reg_write_d = 1'b0;
        end
    end

    always_comb begin
        case (imm_src)
            IMM12:   ext_imm_d = {20'b0, instr_d[11:0]};
            BR24:    ext_imm_d = {{6{instr_d[23]}}, instr_d[23:0], 2'b00};
            default: ext_imm_d = {24'b0, instr_d[7:0]};
        endcase
    end

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .ra1      (ra1_d),
        .ra2      (ra2_d),
        .pc_plus8 (pc_d + `PC_STEP + `PC_STEP),
        .we       (reg_write_w),
        .wa       (wa3_w),
        .wd       (result_w),
        .rd1      (rd1_d),
        .rd2      (rd2_d)
    );

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bubble_e,
    input  logic [`REG_ADDR_W-1:0] wa3_d,
    input  logic [`WORD_W-1:0]     rd1_d,
    input  logic [`WORD_W-1:0]     rd2_d,
    input  logic [`WORD_W-1:0]     ext_imm_d,
    input  isa_pkg::alu_cmd_e      alu_cmd_d,
    input  isa_pkg::cond_e         cond_d,
    input  logic                   alu_src_d,
    input  logic                   set_flags_d,
    input  logic                   reg_write_d,
    input  logic                   mem_write_d,
    input  logic                   mem_to_reg_d,
    input  logic                   branch_d,
    input  pipe_pkg::fwd_sel_e     fwd_a_e,
    input  pipe_pkg::fwd_sel_e     fwd_b_e,
    input  logic [`WORD_W-1:0]     alu_out_m,
    input  logic [`WORD_W-1:0]     result_w,
    output logic [`WORD_W-1:0]     alu_result_e,
    output logic [`WORD_W-1:0]     write_data_e,
    output logic [`REG_ADDR_W-1:0] wa3_e,
    output logic                   reg_write_e,
    output logic                   mem_write_e,
    output logic                   mem_to_reg_e,
    output logic                   branch_taken_e,
    output logic [`WORD_W-1:0]     branch_target_e
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`WORD_W-1:0] rd1_q;
    logic [`WORD_W-1:0] rd2_q;
    logic [`WORD_W-1:0] ext_imm_q;
    alu_cmd_e           alu_cmd_q;
    cond_e              cond_q;
    logic               alu_src_q;
    logic               set_flags_q;
    logic               reg_write_q;
    logic               mem_write_q;
    logic               branch_q;
    logic               flag_n;
    logic               flag_z;
    logic               cond_ok;
    logic [`WORD_W-1:0] src_a;
    logic [`WORD_W-1:0] src_b;

    ////////////////////
    // id/ex register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            set_flags_q  <= 1'b0;
            reg_write_q  <= 1'b0;
            mem_write_q  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            branch_q     <= 1'b0;
        end else begin
            // a bubble drops every side effect
            set_flags_q  <= set_flags_d && !bubble_e;
            reg_write_q  <= reg_write_d && !bubble_e;
            mem_write_q  <= mem_write_d && !bubble_e;
            mem_to_reg_e <= mem_to_reg_d && !bubble_e;
            branch_q     <= branch_d && !bubble_e;
        end
    end

    always_ff @(posedge clk) begin
        rd1_q     <= rd1_d;
        rd2_q     <= rd2_d;
        ext_imm_q <= ext_imm_d;
        alu_cmd_q <= alu_cmd_d;
        cond_q    <= cond_d;
        alu_src_q <= alu_src_d;
        wa3_e     <= wa3_d;
    end

    function automatic logic [`WORD_W-1:0] fwd_mux(input fwd_sel_e sel,
                                                   input logic [`WORD_W-1:0] reg_val);
        case (sel)
            FWD_MEM: return alu_out_m;
            FWD_WB:  return result_w;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////
    // operands and alu
    assign src_a        = fwd_mux(fwd_a_e, rd1_q);
    assign write_data_e = fwd_mux(fwd_b_e, rd2_q);
    assign src_b        = alu_src_q ? ext_imm_q : write_data_e;

    always_comb begin
        case (alu_cmd_q)
            AND:     alu_result_e = src_a & src_b;
            SUB:     alu_result_e = src_a - src_b;
            CMP:     alu_result_e = src_a - src_b;
            ORR:     alu_result_e = src_a | src_b;
            MOV:     alu_result_e = src_b;
            default: alu_result_e = src_a + src_b;
        endcase
    end

    // codes outside the five never execute
    always_comb begin
        case (cond_q)
            EQ:      cond_ok = flag_z;
            NE:      cond_ok = !flag_z;
            MI:      cond_ok = flag_n;
            PL:      cond_ok = !flag_n;
            AL:      cond_ok = 1'b1;
            default: cond_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flag_n <= 1'b0;
            flag_z <= 1'b0;
        end else if (set_flags_q && cond_ok) begin
            flag_n <= alu_result_e[`WORD_W-1];
            flag_z <= alu_result_e == '0;
        end
    end

    assign reg_write_e     = reg_write_q && cond_ok;
    assign mem_write_e     = mem_write_q && cond_ok;
    assign branch_taken_e  = branch_q && cond_ok;
    assign branch_target_e = alu_result_e;

endmodule

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_wb_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`WORD_W-1:0]     alu_result_e,
    input  logic [`WORD_W-1:0]     write_data_e,
    input  logic [`REG_ADDR_W-1:0] wa3_e,
    input  logic                   reg_write_e,
    input  logic                   mem_write_e,
    input  logic                   mem_to_reg_e,
    input  logic [`WORD_W-1:0]     dmem_rdata,
    output logic [`WORD_W-1:0]     dmem_addr,
    output logic [`WORD_W-1:0]     dmem_wdata,
    output logic                   dmem_we,
    output logic [`WORD_W-1:0]     alu_out_m,
    output logic [`REG_ADDR_W-1:0] wa3_m,
    output logic                   reg_write_m,
    output logic                   mem_to_reg_m,
    output logic [`WORD_W-1:0]     result_w,
    output logic [`REG_ADDR_W-1:0] wa3_w,
    output logic                   reg_write_w
);

    logic               mem_to_reg_w;
    logic [`WORD_W-1:0] alu_out_w;
    logic [`WORD_W-1:0] read_data_w;

    ////////////////////
    // ex/m and m/w control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
            dmem_we      <= 1'b0;
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_to_reg_m <= mem_to_reg_e;
            dmem_we      <= mem_write_e;
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_out_m   <= alu_result_e;
        dmem_wdata  <= write_data_e;
        wa3_m       <= wa3_e;
        alu_out_w   <= alu_out_m;
        read_data_w <= dmem_rdata;
        wa3_w       <= wa3_m;
    end

    assign dmem_addr = alu_out_m;
    assign result_w  = mem_to_reg_w ? read_data_w : alu_out_w;

endmodule

// ==== design/pipeline_control.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pipeline_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] ra1_d,
    input  logic [`REG_ADDR_W-1:0] ra2_d,
    input  logic [`REG_ADDR_W-1:0] wa3_e,
    input  logic                   mem_to_reg_e,
    input  logic                   reg_write_m,
    input  logic [`REG_ADDR_W-1:0] wa3_m,
    input  logic                   reg_write_w,
    input  logic [`REG_ADDR_W-1:0] wa3_w,
    input  logic                   branch_taken_e,
    input  logic [`WORD_W-1:0]     branch_target_e,
    output logic [`WORD_W-1:0]     imem_addr,
    output logic                   stall_f_d,
    output logic                   bubble_e,
    output logic                   flush_d,
    output pipe_pkg::fwd_sel_e     fwd_a_e,
    output pipe_pkg::fwd_sel_e     fwd_b_e
);
    import pipe_pkg::*;

    logic [`REG_ADDR_W-1:0] ra1_e;
    logic [`REG_ADDR_W-1:0] ra2_e;
    logic                   load_use;

    ////////////////////
    // hazards
    assign load_use  = mem_to_reg_e && (ra1_d == wa3_e || ra2_d == wa3_e);
    assign stall_f_d = load_use;
    assign bubble_e  = load_use || branch_taken_e;
    assign flush_d   = branch_taken_e;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imem_addr <= `PC_RESET;
        end else if (branch_taken_e) begin
            imem_addr <= branch_target_e;
        end else if (!load_use) begin
            imem_addr <= imem_addr + `PC_STEP;
        end
    end

    // source indexes of the instruction now in execute
    always_ff @(posedge clk) begin
        ra1_e <= ra1_d;
        ra2_e <= ra2_d;
    end

    // memory stage is younger, so it wins
    function automatic fwd_sel_e fwd_select(input logic [`REG_ADDR_W-1:0] ra);
        if (reg_write_m && wa3_m == ra) begin
            return FWD_MEM;
        end else if (reg_write_w && wa3_w == ra) begin
            return FWD_WB;
        end else begin
            return FWD_REG;
        end
    endfunction

    assign fwd_a_e = fwd_select(ra1_e);
    assign fwd_b_e = fwd_select(ra2_e);

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core (
    input  logic                clk,
    input  logic                reset,
    output logic [`WORD_W-1:0]  imem_addr,
    input  logic [`WORD_W-1:0]  imem_data,
    output logic [`WORD_W-1:0]  dmem_addr,
    output logic [`WORD_W-1:0]  dmem_wdata,
    output logic                dmem_we,
    input  logic [`WORD_W-1:0]  dmem_rdata
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // hazard unit
    logic                   stall_f_d;
    logic                   bubble_e;
    logic                   flush_d;
    fwd_sel_e               fwd_a_e;
    fwd_sel_e               fwd_b_e;

    // decode to execute
    logic [`REG_ADDR_W-1:0] ra1_d;
    logic [`REG_ADDR_W-1:0] ra2_d;
    logic [`REG_ADDR_W-1:0] wa3_d;
    logic [`WORD_W-1:0]     rd1_d;
    logic [`WORD_W-1:0]     rd2_d;
    logic [`WORD_W-1:0]     ext_imm_d;
    alu_cmd_e               alu_cmd_d;
    cond_e                  cond_d;
    logic                   alu_src_d;
    logic                   set_flags_d;
    logic                   reg_write_d;
    logic                   mem_write_d;
    logic                   mem_to_reg_d;
    logic                   branch_d;

    // execute, memory and writeback
    logic [`WORD_W-1:0]     alu_result_e;
    logic [`WORD_W-1:0]     write_data_e;
    logic [`REG_ADDR_W-1:0] wa3_e;
    logic                   reg_write_e;
    logic                   mem_write_e;
    logic                   mem_to_reg_e;
    logic                   branch_taken_e;
    logic [`WORD_W-1:0]     branch_target_e;
    logic [`WORD_W-1:0]     alu_out_m;
    logic [`REG_ADDR_W-1:0] wa3_m;
    logic                   reg_write_m;
    logic                   mem_to_reg_m;
    logic [`WORD_W-1:0]     result_w;
    logic [`REG_ADDR_W-1:0] wa3_w;
    logic                   reg_write_w;

    decode_stage u_decode (
        .instr_f (imem_data),
        .pc_f    (imem_addr),
        .*
    );

    execute_stage u_execute (.*);

    mem_wb_stage u_mem_wb (.*);

    pipeline_control u_control (.*);

endmodule

// ==== verification/cpu_props.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_props (
    input logic               clk,
    input logic               reset,
    input logic [`WORD_W-1:0] imem_addr,
    input logic               dmem_we,
    input logic               stall_f_d
);

    a_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(dmem_we) && !$isunknown(imem_addr))
        else $error("dmem_we or imem_addr is unknown");

    a_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr is not word aligned");

    // pc frozen for the load-use bubble
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        stall_f_d |=> $stable(imem_addr))
        else $error("imem_addr moved during a stall");

endmodule

// ==== verification/cpu_checker.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_checker (
    input logic               clk,
    input logic               reset,
    input logic [`WORD_W-1:0] imem_addr,
    input logic               dmem_we,
    input logic [`WORD_W-1:0] dmem_addr,
    input logic [`WORD_W-1:0] dmem_wdata
);

    localparam logic [`WORD_W-1:0] END_ADDR = 32'h0000_00FC;

    int                 value_errors = 0;
    int                 store_errors = 0;
    int                 reset_errors = 0;
    string              test_name;
    logic [`WORD_W-1:0] exp_addr [4];
    logic [`WORD_W-1:0] exp_data [4];
    int                 exp_count = 0;
    int                 next_idx = 0;
    logic               clocked = 1'b0;

    task automatic begin_test(input string name);
        test_name = name;
        exp_count = 0;
        next_idx  = 0;
    endtask

    task automatic add_store(input logic [`WORD_W-1:0] addr, input logic [`WORD_W-1:0] data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    task automatic end_test();
        if (next_idx < exp_count) begin
            $display("test %s: only %0d of %0d expected stores were seen",
                     test_name, next_idx, exp_count);
            store_errors++;
        end
    endtask

    always @(posedge clk) begin
        clocked <= 1'b1;
    end

    ////////////////////
    // store compare
    always @(negedge clk) begin
        if (reset && clocked) begin
            if (dmem_we !== 1'b0 || imem_addr !== `PC_RESET) begin
                $display("FAIL %s: reset expected dmem_we 0 fetch %h, actual dmem_we %b fetch %h",
                         test_name, `PC_RESET, dmem_we, imem_addr);
                reset_errors++;
            end
        end else if (!reset && dmem_we && dmem_addr != END_ADDR) begin
            if (next_idx >= exp_count) begin
                $display("test %s: extra store of %h to address %h",
                         test_name, dmem_wdata, dmem_addr);
                store_errors++;
            end else begin
                if (dmem_addr !== exp_addr[next_idx] || dmem_wdata !== exp_data[next_idx]) begin
                    $display("FAIL %s: expected %h at %h, actual %h at %h", test_name,
                             exp_data[next_idx], exp_addr[next_idx], dmem_wdata, dmem_addr);
                    value_errors++;
                end
                next_idx++;
            end
        end
    end

endmodule

// ==== verification/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu;
    import isa_pkg::*;

    localparam int                 NUM_TESTS = 6;
    localparam int                 TIMEOUT   = 200;
    localparam logic [`WORD_W-1:0] END_ADDR  = 32'h0000_00FC;
    // cond 1111 never executes
    localparam logic [`WORD_W-1:0] NEVER     = 32'hF000_0000;

    logic               clk;
    logic               reset;
    logic [`WORD_W-1:0] imem_addr;
    logic [`WORD_W-1:0] imem_data;
    logic [`WORD_W-1:0] dmem_addr;
    logic [`WORD_W-1:0] dmem_wdata;
    logic               dmem_we;
    logic [`WORD_W-1:0] dmem_rdata;

    logic [`WORD_W-1:0] imem [0:63];
    logic [`WORD_W-1:0] dmem [0:63];

    string              test_names [NUM_TESTS];
    logic [`WORD_W-1:0] programs   [NUM_TESTS][16];
    logic [`WORD_W-1:0] exp_addr   [NUM_TESTS][4];
    logic [`WORD_W-1:0] exp_data   [NUM_TESTS][4];
    int                 exp_count  [NUM_TESTS];
    int                 cur_t;
    int                 cur_n;
    bit                 timed_out;

    cpu_core UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    cpu_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    bind cpu_core cpu_props u_props (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .dmem_we   (dmem_we),
        .stall_f_d (stall_f_d)
    );

    always #4 clk = ~clk;

    ////////////////////
    // memory models
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] = dmem_wdata;
        end
    end

    ////////////////////
    // instruction encoders
    function automatic logic [31:0] data_instr(input cond_e c, input logic imm,
                                               input alu_cmd_e op, input logic s,
                                               input logic [3:0] rn, input logic [3:0] rd,
                                               input logic [7:0] op2);
        return {c, 2'b00, imm, op, s, rn, rd, 4'b0000, op2};
    endfunction

    function automatic logic [31:0] load_store(input logic load, input logic [3:0] rn,
                                               input logic [3:0] rd, input logic [11:0] off);
        return {AL, 2'b01, 5'b01100, load, rn, rd, off};
    endfunction

    function automatic logic [31:0] branch_to(input cond_e c, input logic [23:0] off);
        return {c, 4'b1010, off};
    endfunction

    task automatic open_program(input string name);
        test_names[cur_t] = name;
        exp_count[cur_t]  = 0;
        cur_n             = 0;
        for (int i = 0; i < 16; i++) begin
            programs[cur_t][i] = NEVER;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        programs[cur_t][cur_n] = word;
        cur_n++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[cur_t][exp_count[cur_t]] = addr;
        exp_data[cur_t][exp_count[cur_t]] = data;
        exp_count[cur_t]++;
    endtask

    // end marker store, then a branch to itself
    task automatic close_program();
        emit(load_store(1'b0, 4'd14, 4'd0, 12'hFC));
        emit(branch_to(AL, 24'hFF_FFFE));
        cur_t++;
    endtask

    task automatic build_programs();
        cur_t = 0;
        open_program("reset");
        close_program();

        open_program("alu_forward");
        emit(data_instr(AL, 1'b1, MOV, 1'b0, 4'd0, 4'd1, 8'd5));
        emit(data_instr(AL, 1'b1, ADD, 1'b0, 4'd1, 4'd2, 8'd3));
        emit(data_instr(AL, 1'b0, SUB, 1'b0, 4'd2, 4'd3, 8'd1));
        emit(data_instr(AL, 1'b1, AND, 1'b0, 4'd3, 4'd4, 8'd6));
        emit(data_instr(AL, 1'b0, ORR, 1'b0, 4'd4, 4'd5, 8'd2));
        emit(data_instr(AL, 1'b0, MOV, 1'b0, 4'd0, 4'd6, 8'd5));
        emit(load_store(1'b0, 4'd14, 4'd6, 12'h000));
        emit(load_store(1'b0, 4'd14, 4'd3, 12'h004));
        expect_store(32'h00, ((32'd5 + 32'd3 - 32'd5) & 32'd6) | (32'd5 + 32'd3));
        expect_store(32'h04, 32'd5 + 32'd3 - 32'd5);
        close_program();

        open_program("load_use");
        emit(load_store(1'b1, 4'd14, 4'd1, 12'h020));
        emit(data_instr(AL, 1'b1, ADD, 1'b0, 4'd1, 4'd2, 8'd7));
        emit(load_store(1'b0, 4'd14, 4'd2, 12'h010));
        expect_store(32'h10, dmem[8] + 32'd7);
        close_program();

        open_program("cond_exec");
        // 0 - 0 is zero and not negative
        emit(data_instr(AL, 1'b1, CMP, 1'b1, 4'd0, 4'd0, 8'd0));
        emit(data_instr(EQ, 1'b1, MOV, 1'b0, 4'd0, 4'd2, 8'd1));
        emit(data_instr(NE, 1'b1, MOV, 1'b0, 4'd0, 4'd3, 8'd1));
        emit(data_instr(MI, 1'b1, MOV, 1'b0, 4'd0, 4'd4, 8'd1));
        emit(data_instr(PL, 1'b1, MOV, 1'b0, 4'd0, 4'd5, 8'd1));
        // 0 - 1 is negative and nonzero
        emit(data_instr(AL, 1'b1, CMP, 1'b1, 4'd0, 4'd0, 8'd1));
        emit(data_instr(EQ, 1'b1, ADD, 1'b0, 4'd2, 4'd2, 8'd4));
        emit(data_instr(NE, 1'b1, ADD, 1'b0, 4'd3, 4'd3, 8'd2));
        emit(data_instr(MI, 1'b1, ADD, 1'b0, 4'd4, 4'd4, 8'd2));
        emit(data_instr(PL, 1'b1, ADD, 1'b0, 4'd5, 4'd5, 8'd4));
        emit(load_store(1'b0, 4'd14, 4'd2, 12'h040));
        emit(load_store(1'b0, 4'd14, 4'd3, 12'h044));
        emit(load_store(1'b0, 4'd14, 4'd4, 12'h048));
        emit(load_store(1'b0, 4'd14, 4'd5, 12'h04C));
        expect_store(32'h40, 32'd1);
        expect_store(32'h44, 32'd0 + 32'd2);
        expect_store(32'h48, 32'd0 + 32'd2);
        expect_store(32'h4C, 32'd1);
        close_program();

        open_program("branch");
        emit(data_instr(AL, 1'b1, MOV, 1'b0, 4'd0, 4'd1, 8'd7));
        // branch at 4 lands on 4 + 8 + 4
        emit(branch_to(AL, 24'd1));
        emit(load_store(1'b0, 4'd14, 4'd1, 12'h050));
        emit(load_store(1'b0, 4'd14, 4'd1, 12'h054));
        emit(data_instr(AL, 1'b1, CMP, 1'b1, 4'd1, 4'd0, 8'd7));
        emit(branch_to(NE, 24'd1));
        emit(load_store(1'b0, 4'd14, 4'd1, 12'h058));
        expect_store(32'h58, 32'd7);
        close_program();

        open_program("pc_read");
        emit(data_instr(AL, 1'b1, MOV, 1'b0, 4'd0, 4'd1, 8'd1));
        emit(data_instr(AL, 1'b0, MOV, 1'b0, 4'd0, 4'd2, 8'd15));
        emit(load_store(1'b0, 4'd14, 4'd2, 12'h060));
        emit(load_store(1'b0, 4'd14, 4'd15, 12'h064));
        expect_store(32'h60, 32'd4 + 32'd8);
        expect_store(32'h64, 32'd12 + 32'd8);
        close_program();
    endtask

    ////////////////////
    // run loop
    initial begin
        int  cycles;
        bit  found;

        clk       = 1'b0;
        reset     = 1'b1;
        timed_out = 1'b0;
        void'($urandom(66));
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom;
            imem[i] <= NEVER;
        end
        build_programs();

        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            for (int i = 0; i < 64; i++) begin
                imem[i] <= (i < 16) ? programs[t][i] : NEVER;
            end
            u_checker.begin_test(test_names[t]);
            for (int k = 0; k < exp_count[t]; k++) begin
                u_checker.add_store(exp_addr[t][k], exp_data[t][k]);
            end
            repeat (3) @(posedge clk);
            reset <= 1'b0;

            // wait for the end marker store
            found  = 1'b0;
            cycles = 0;
            while (!found && cycles < TIMEOUT) begin
                @(negedge clk);
                found = dmem_we && dmem_addr == END_ADDR;
                cycles++;
            end
            if (found) begin
                u_checker.end_test();
            end else begin
                $display("test %s never reached its end store within %0d cycles",
                         test_names[t], TIMEOUT);
                timed_out = 1'b1;
            end
        end

        $display("errors: %0d value, %0d store count, %0d reset, %0d timeout",
                 u_checker.value_errors, u_checker.store_errors,
                 u_checker.reset_errors, timed_out);
        if (u_checker.value_errors == 0 && u_checker.store_errors == 0 &&
            u_checker.reset_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/pipeline_control.sv
design/cpu_core.sv
verification/cpu_props.sv
verification/cpu_checker.sv
verification/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_cpu -o tb_cpu_sim

./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
